// ==== all.f ====
hw/udp_echo_pkg.sv
hw/frame_parser.sv
hw/payload_fifo.sv
hw/reply_builder.sv
hw/udp_echo.sv
tb/tb_udp_echo.sv

// ==== hw/frame_parser.sv ====
`timescale 1ns/1ps
`default_nettype none

module frame_parser
    import udp_echo_pkg::*;
(
    input  wire         clk,
    input  wire         rst,
    input  wire  [7:0]  in_data,
    input  wire         in_valid,
    output logic        in_ready,
    input  wire         in_last,
    output logic [7:0]  fifo_wr_data,
    output logic        fifo_wr_last,
    output logic        fifo_wr_en,
    input  wire         fifo_full,
    output logic        hdr_valid,
    input  wire         hdr_taken,
    output logic [47:0] peer_mac,
    output logic [31:0] peer_ip,
    output logic [15:0] peer_port,
    output logic [15:0] udp_length
);

    logic [5:0]  byte_cnt;
    logic        in_payload;
    logic        dropping;
    logic [15:0] remaining;
    logic [47:0] src_mac;
    logic [15:0] eth_type;
    logic [7:0]  ip_proto;
    logic [31:0] src_ip;
    logic [31:0] dst_ip;
    logic [15:0] src_port;
    logic [15:0] dst_port;
    logic [15:0] len_field;
    logic [15:0] payload_len;
    logic        hdr_end;
    logic        match;
    logic        accept;
    logic        beat;

    assign hdr_end = !in_payload && !dropping && byte_cnt == 6'(FRAME_HDR_BYTES - 1);
    assign match = eth_type == ETHERTYPE_IPV4 && ip_proto == IP_PROTO_UDP &&
                   dst_ip == LOCAL_IP && dst_port == ECHO_PORT;
    assign payload_len = (len_field > 16'(UDP_HDR_BYTES)) ?
                         len_field - 16'(UDP_HDR_BYTES) : 16'd0;

    // A frame that ends right after its header cannot supply the payload it announces
    assign accept = hdr_end && match && (payload_len == 16'd0 || !in_last);

    // Last header byte waits until the builder has taken the previous header
    always_comb begin
        if (in_payload) begin
            in_ready = !fifo_full;
        end else if (hdr_end) begin
            in_ready = !hdr_valid;
        end else begin
            in_ready = 1'b1;
        end
    end

    assign beat = in_valid && in_ready;

    assign fifo_wr_en = beat && in_payload;
    assign fifo_wr_data = in_data;
    assign fifo_wr_last = in_last || remaining == 16'd1;

    // Header fields, big endian on the wire
    always_ff @(posedge clk) begin
        if (beat && !in_payload && !dropping) begin
            case (byte_cnt)
                6, 7, 8, 9, 10, 11: src_mac <= {src_mac[39:0], in_data};
                12, 13: eth_type <= {eth_type[7:0], in_data};
                23: ip_proto <= in_data;
                26, 27, 28, 29: src_ip <= {src_ip[23:0], in_data};
                30, 31, 32, 33: dst_ip <= {dst_ip[23:0], in_data};
                34, 35: src_port <= {src_port[7:0], in_data};
                36, 37: dst_port <= {dst_port[7:0], in_data};
                38, 39: len_field <= {len_field[7:0], in_data};
                default: ;
            endcase
        end
    end

    // Held for the builder while the next header is collected
    always_ff @(posedge clk) begin
        if (beat && accept) begin
            peer_mac <= src_mac;
            peer_ip <= src_ip;
            peer_port <= src_port;
            udp_length <= len_field;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            byte_cnt <= 6'd0;
            in_payload <= 1'b0;
            dropping <= 1'b0;
            remaining <= 16'd0;
            hdr_valid <= 1'b0;
        end else begin
            if (hdr_taken) begin
                hdr_valid <= 1'b0;
            end
            if (beat) begin
                if (in_payload) begin
                    remaining <= remaining - 16'd1;
                    if (in_last) begin
                        in_payload <= 1'b0;
                    end else if (remaining == 16'd1) begin
                        // Ethernet padding follows
                        in_payload <= 1'b0;
                        dropping <= 1'b1;
                    end
                end else if (dropping) begin
                    if (in_last) begin
                        dropping <= 1'b0;
                    end
                end else begin
                    byte_cnt <= (hdr_end || in_last) ? 6'd0 : byte_cnt + 6'd1;
                    if (accept) begin
                        hdr_valid <= 1'b1;
                        remaining <= payload_len;
                        in_payload <= payload_len != 16'd0;
                        dropping <= payload_len == 16'd0 && !in_last;
                    end else if (hdr_end) begin
                        dropping <= !in_last;
                    end
                end
            end
        end
    end

    assert property (@(posedge clk) disable iff (rst) !(fifo_wr_en && fifo_full));

endmodule

`default_nettype wire

// ==== hw/payload_fifo.sv ====
`timescale 1ns/1ps
`default_nettype none

module payload_fifo
    import udp_echo_pkg::*;
(
    input  wire        clk,
    input  wire        rst,
    input  wire  [7:0] fifo_wr_data,
    input  wire        fifo_wr_last,
    input  wire        fifo_wr_en,
    output logic       fifo_full,
    output logic [7:0] fifo_rd_data,
    output logic       fifo_rd_last,
    input  wire        fifo_rd_en,
    output logic       fifo_empty
);

    // Each entry holds the last flag above the data byte
    logic [8:0] mem [FIFO_DEPTH];
    logic [FIFO_ADDR_BITS:0] wr_ptr;
    logic [FIFO_ADDR_BITS:0] rd_ptr;

    assign fifo_empty = wr_ptr == rd_ptr;
    assign fifo_full = wr_ptr[FIFO_ADDR_BITS] != rd_ptr[FIFO_ADDR_BITS] &&
                       wr_ptr[FIFO_ADDR_BITS-1:0] == rd_ptr[FIFO_ADDR_BITS-1:0];

    // Head entry is visible without a read strobe
    assign {fifo_rd_last, fifo_rd_data} = mem[rd_ptr[FIFO_ADDR_BITS-1:0]];

    always_ff @(posedge clk) begin
        if (fifo_wr_en && !fifo_full) begin
            mem[wr_ptr[FIFO_ADDR_BITS-1:0]] <= {fifo_wr_last, fifo_wr_data};
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else begin
            if (fifo_wr_en && !fifo_full) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (fifo_rd_en && !fifo_empty) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
        end
    end

    assert property (@(posedge clk) disable iff (rst) !(fifo_rd_en && fifo_empty));

endmodule

`default_nettype wire

// ==== hw/reply_builder.sv ====
`timescale 1ns/1ps
`default_nettype none

module reply_builder
    import udp_echo_pkg::*;
(
    input  wire         clk,
    input  wire         rst,
    input  wire         hdr_valid,
    output logic        hdr_taken,
    input  wire  [47:0] peer_mac,
    input  wire  [31:0] peer_ip,
    input  wire  [15:0] peer_port,
    input  wire  [15:0] udp_length,
    input  wire  [7:0]  fifo_rd_data,
    input  wire         fifo_rd_last,
    output logic        fifo_rd_en,
    input  wire         fifo_empty,
    output logic [7:0]  out_data,
    output logic        out_valid,
    input  wire         out_ready,
    output logic        out_last
);

    logic        send_hdr;
    logic        send_pay;
    logic [5:0]  byte_idx;
    logic [47:0] mac_r;
    logic [31:0] ip_r;
    logic [15:0] port_r;
    logic [15:0] udp_len_r;
    logic [15:0] ip_len_r;
    logic [15:0] csum_r;
    logic [15:0] ip_len;
    logic [18:0] csum_sum;
    logic [16:0] csum_fold;
    logic [15:0] csum;
    logic [FRAME_HDR_BYTES*8-1:0] hdr_vec;
    logic        last_hdr_byte;
    logic        no_payload;

    assign hdr_taken = hdr_valid && !send_hdr && !send_pay;
    assign ip_len = udp_length + 16'(IP_HDR_BYTES);

    // Ones' complement sum of the IPv4 header, all-zero words left out
    always_comb begin
        csum_sum = 19'h04500 + 19'(ip_len) + 19'({REPLY_TTL, IP_PROTO_UDP}) +
                   19'(LOCAL_IP[31:16]) + 19'(LOCAL_IP[15:0]) +
                   19'(peer_ip[31:16]) + 19'(peer_ip[15:0]);
        csum_fold = 17'(csum_sum[15:0]) + 17'(csum_sum[18:16]);
        csum = ~(csum_fold[15:0] + 16'(csum_fold[16]));
    end

    always_ff @(posedge clk) begin
        if (hdr_taken) begin
            mac_r <= peer_mac;
            ip_r <= peer_ip;
            port_r <= peer_port;
            udp_len_r <= udp_length;
            ip_len_r <= ip_len;
            csum_r <= csum;
        end
    end

    // Reply header in wire order, first byte in the top bits
    assign hdr_vec = {mac_r, LOCAL_MAC, ETHERTYPE_IPV4,
                      8'h45, 8'h00, ip_len_r, 32'h0000_0000,
                      REPLY_TTL, IP_PROTO_UDP, csum_r, LOCAL_IP, ip_r,
                      ECHO_PORT, port_r, udp_len_r, 16'h0000};

    assign last_hdr_byte = byte_idx == 6'(FRAME_HDR_BYTES - 1);
    assign no_payload = udp_len_r <= 16'(UDP_HDR_BYTES);

    assign out_valid = send_hdr || (send_pay && !fifo_empty);
    assign out_data = send_hdr ? hdr_vec[(FRAME_HDR_BYTES - 1 - byte_idx) * 8 +: 8] :
                      fifo_rd_data;
    assign out_last = send_hdr ? (last_hdr_byte && no_payload) : fifo_rd_last;
    assign fifo_rd_en = send_pay && out_ready && !fifo_empty;

    always_ff @(posedge clk) begin
        if (rst) begin
            send_hdr <= 1'b0;
            send_pay <= 1'b0;
            byte_idx <= 6'd0;
        end else if (hdr_taken) begin
            send_hdr <= 1'b1;
            byte_idx <= 6'd0;
        end else if (send_hdr && out_ready) begin
            if (last_hdr_byte) begin
                send_hdr <= 1'b0;
                send_pay <= !no_payload;
            end else begin
                byte_idx <= byte_idx + 6'd1;
            end
        end else if (fifo_rd_en && fifo_rd_last) begin
            send_pay <= 1'b0;
        end
    end

    // Stalled byte holds, whether it comes from the header or the FIFO head
    assert property (@(posedge clk) disable iff (rst)
        out_valid && !out_ready |=> out_valid && $stable(out_data) && $stable(out_last));

endmodule

`default_nettype wire

// ==== hw/udp_echo.sv ====
`timescale 1ns/1ps
`default_nettype none

module udp_echo (
    input  wire        clk,
    input  wire        rst,
    input  wire  [7:0] in_data,
    input  wire        in_valid,
    output logic       in_ready,
    input  wire        in_last,
    output logic [7:0] out_data,
    output logic       out_valid,
    input  wire        out_ready,
    output logic       out_last
);

    logic [7:0]  fifo_wr_data;
    logic        fifo_wr_last;
    logic        fifo_wr_en;
    logic        fifo_full;
    logic [7:0]  fifo_rd_data;
    logic        fifo_rd_last;
    logic        fifo_rd_en;
    logic        fifo_empty;
    logic        hdr_valid;
    logic        hdr_taken;
    logic [47:0] peer_mac;
    logic [31:0] peer_ip;
    logic [15:0] peer_port;
    logic [15:0] udp_length;

    frame_parser frame_parser_i (
        .clk          (clk),
        .rst          (rst),
        .in_data      (in_data),
        .in_valid     (in_valid),
        .in_ready     (in_ready),
        .in_last      (in_last),
        .fifo_wr_data (fifo_wr_data),
        .fifo_wr_last (fifo_wr_last),
        .fifo_wr_en   (fifo_wr_en),
        .fifo_full    (fifo_full),
        .hdr_valid    (hdr_valid),
        .hdr_taken    (hdr_taken),
        .peer_mac     (peer_mac),
        .peer_ip      (peer_ip),
        .peer_port    (peer_port),
        .udp_length   (udp_length)
    );

    payload_fifo payload_fifo_i (
        .clk          (clk),
        .rst          (rst),
        .fifo_wr_data (fifo_wr_data),
        .fifo_wr_last (fifo_wr_last),
        .fifo_wr_en   (fifo_wr_en),
        .fifo_full    (fifo_full),
        .fifo_rd_data (fifo_rd_data),
        .fifo_rd_last (fifo_rd_last),
        .fifo_rd_en   (fifo_rd_en),
        .fifo_empty   (fifo_empty)
    );

    reply_builder reply_builder_i (
        .clk          (clk),
        .rst          (rst),
        .hdr_valid    (hdr_valid),
        .hdr_taken    (hdr_taken),
        .peer_mac     (peer_mac),
        .peer_ip      (peer_ip),
        .peer_port    (peer_port),
        .udp_length   (udp_length),
        .fifo_rd_data (fifo_rd_data),
        .fifo_rd_last (fifo_rd_last),
        .fifo_rd_en   (fifo_rd_en),
        .fifo_empty   (fifo_empty),
        .out_data     (out_data),
        .out_valid    (out_valid),
        .out_ready    (out_ready),
        .out_last     (out_last)
    );

endmodule

`default_nettype wire

// ==== hw/udp_echo_pkg.sv ====
`default_nettype none

package udp_echo_pkg;

    // Responder identity
    localparam logic [47:0] LOCAL_MAC = 48'h02_00_00_00_00_00;
    localparam logic [31:0] LOCAL_IP = {8'd192, 8'd168, 8'd2, 8'd128};
    localparam logic [15:0] ECHO_PORT = 16'd1234;

    // Protocol constants
    localparam logic [15:0] ETHERTYPE_IPV4 = 16'h0800;
    localparam logic [7:0] IP_PROTO_UDP = 8'd17;
    localparam logic [7:0] REPLY_TTL = 8'd64;

    // Header sizes in bytes, IPv4 without options
    localparam int ETH_HDR_BYTES = 14;
    localparam int IP_HDR_BYTES = 20;
    localparam int UDP_HDR_BYTES = 8;
    localparam int FRAME_HDR_BYTES = ETH_HDR_BYTES + IP_HDR_BYTES + UDP_HDR_BYTES;

    // Payload buffer
    localparam int FIFO_DEPTH = 2048;
    localparam int FIFO_ADDR_BITS = 11;

endpackage

`default_nettype wire

// ==== tb/tb_udp_echo.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_udp_echo
    import udp_echo_pkg::*;
;

    logic        clk;
    logic        rst;
    logic [7:0]  in_data;
    logic        in_valid;
    logic        in_ready;
    logic        in_last;
    logic [7:0]  out_data;
    logic        out_valid;
    logic        out_ready;
    logic        out_last;

    logic [31:0] lfsr_state = 32'h8704_aa9d;
    logic [8:0]  exp_q[$];
    logic [8:0]  exp_word;
    logic [7:0]  pay_buf [0:511];
    logic [7:0]  frm [0:1023];
    logic        ready_pat [0:4095];
    logic        random_ready;
    int          rdy_idx;
    int          rand_len [0:9];
    int          total_bytes;
    int          cycle_cnt;
    int          cycle_limit = 100000;
    int          checks;
    int          errors;
    int          test_errors;
    int          tests_failed;

    udp_echo udp_echo_i (
        .clk       (clk),
        .rst       (rst),
        .in_data   (in_data),
        .in_valid  (in_valid),
        .in_ready  (in_ready),
        .in_last   (in_last),
        .out_data  (out_data),
        .out_valid (out_valid),
        .out_ready (out_ready),
        .out_last  (out_last)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // Fibonacci LFSR with taps 32 22 2 1 stepped once per bit
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = {lfsr_state[30:0],
                          lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0]};
            r = {r[30:0], lfsr_state[0]};
        end
        return r;
    endfunction

    // Expected reply bytes of one echoed frame with its payload from pay_buf
    function automatic void expect_reply(input logic [47:0] mac, input logic [31:0] ip,
                                         input logic [15:0] port, input int len);
        logic [FRAME_HDR_BYTES*8-1:0] hdr;
        logic [15:0] ulen;
        logic [31:0] sum;
        ulen = 16'(len + 8);
        hdr = {mac, LOCAL_MAC, 16'h0800, 8'h45, 8'h00, ulen + 16'd20, 32'h0,
               8'd64, 8'd17, 16'h0, LOCAL_IP, ip, 16'd1234, port, ulen, 16'h0};
        sum = 0;
        for (int k = 0; k < 10; k++) begin
            sum = sum + hdr[FRAME_HDR_BYTES*8-1 - 8*(14 + 2*k) -: 16];
        end
        sum = sum[15:0] + sum[31:16];
        sum = sum[15:0] + sum[31:16];
        hdr[FRAME_HDR_BYTES*8-1 - 8*24 -: 16] = ~sum[15:0];
        for (int i = 0; i < FRAME_HDR_BYTES; i++) begin
            exp_q.push_back({i == FRAME_HDR_BYTES - 1 && len == 0,
                             hdr[FRAME_HDR_BYTES*8-1 - 8*i -: 8]});
        end
        for (int i = 0; i < len; i++) begin
            exp_q.push_back({i == len - 1, pay_buf[i]});
        end
    endfunction

    task automatic send_frame(input logic [15:0] etype, input logic [7:0] proto,
                              input logic [31:0] dst_ip, input logic [15:0] dst_port,
                              input logic [47:0] mac, input logic [31:0] ip,
                              input logic [15:0] port, input int len, input int pad);
        logic [FRAME_HDR_BYTES*8-1:0] hdr;
        logic [15:0] ulen;
        int n;
        ulen = 16'(len + 8);
        hdr = {LOCAL_MAC, mac, etype, 8'h45, 8'h00, ulen + 16'd20, 32'h0,
               8'd64, proto, 16'h0, ip, dst_ip, port, dst_port, ulen, 16'h0};
        for (int i = 0; i < len; i++) begin
            pay_buf[i] = 8'(rand_bits(8));
        end
        if (etype == 16'h0800 && proto == 8'd17 &&
            dst_ip == LOCAL_IP && dst_port == 16'd1234) begin
            expect_reply(mac, ip, port, len);
        end
        n = FRAME_HDR_BYTES + len + pad;
        for (int i = 0; i < n; i++) begin
            if (i < FRAME_HDR_BYTES) begin
                frm[i] = hdr[FRAME_HDR_BYTES*8-1 - 8*i -: 8];
            end else if (i < FRAME_HDR_BYTES + len) begin
                frm[i] = pay_buf[i - FRAME_HDR_BYTES];
            end else begin
                frm[i] = 8'h00;
            end
        end
        // in_ready depends only on registers and is settled at the falling edge
        for (int i = 0; i < n; i++) begin
            @(negedge clk);
            in_valid = 1'b1;
            in_data = frm[i];
            in_last = i == n - 1;
            while (!in_ready) @(negedge clk);
        end
    endtask

    task automatic finish_test(input string name);
        @(negedge clk);
        in_valid = 1'b0;
        in_last = 1'b0;
        while (exp_q.size() != 0) @(posedge clk);
        repeat (20) @(posedge clk);
        if (test_errors == 0) begin
            $display("%s: ok", name);
        end else begin
            $display("%s: %0d errors", name, test_errors);
            tests_failed++;
        end
        test_errors = 0;
    endtask

    always @(negedge clk) begin
        if (random_ready) begin
            out_ready = ready_pat[rdy_idx % 4096];
            rdy_idx++;
        end else begin
            out_ready = 1'b1;
        end
    end

    always @(posedge clk) begin
        if (!rst && out_valid && out_ready) begin
            checks++;
            if (exp_q.size() == 0) begin
                $display("Unexpected output byte %h at %0t with no reply pending",
                         out_data, $time);
                errors++;
                test_errors++;
            end else begin
                exp_word = exp_q.pop_front();
                if (out_data !== exp_word[7:0] || out_last !== exp_word[8]) begin
                    $display("CHECK FAILED at %0t: got %h last %b, expected %h last %b",
                             $time, out_data, out_last, exp_word[7:0], exp_word[8]);
                    errors++;
                    test_errors++;
                end
            end
        end
    end

    initial begin
        while (cycle_cnt < cycle_limit) begin
            @(posedge clk);
            cycle_cnt++;
        end
        $display("Timeout after %0d cycles, replies did not complete", cycle_cnt);
        $display("Simulation FAILED");
        $finish;
    end

    initial begin
        rst = 1'b1;
        in_data = 8'h00;
        in_valid = 1'b0;
        in_last = 1'b0;
        out_ready = 1'b1;
        random_ready = 1'b0;
        for (int i = 0; i < 10; i++) begin
            rand_len[i] = rand_bits(9) % 301;
        end
        for (int i = 0; i < 4096; i++) begin
            ready_pat[i] = 1'(rand_bits(1));
        end
        total_bytes = 58 + 8 * 58 + 56 + 42;
        for (int i = 0; i < 10; i++) begin
            total_bytes += FRAME_HDR_BYTES + rand_len[i];
        end
        cycle_limit = total_bytes * 8 + 2000;
        repeat (3) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;

        send_frame(16'h0800, 8'd17, LOCAL_IP, 16'd1234, 48'h5a_11_22_33_44_55,
                   32'hc0a8_020a, 16'd40000, 16, 0);
        finish_test("test 1 basic echo");

        for (int k = 0; k < 4; k++) begin
            case (k)
                0: send_frame(16'h0800, 8'd17, LOCAL_IP, 16'd1235, 48'h5a_11_22_33_44_55,
                              32'hc0a8_020a, 16'd40000, 16, 0);
                1: send_frame(16'h86dd, 8'd17, LOCAL_IP, 16'd1234, 48'h5a_11_22_33_44_55,
                              32'hc0a8_020a, 16'd40000, 16, 0);
                2: send_frame(16'h0800, 8'd17, LOCAL_IP + 1, 16'd1234, 48'h5a_11_22_33_44_55,
                              32'hc0a8_020a, 16'd40000, 16, 0);
                default: send_frame(16'h0800, 8'd6, LOCAL_IP, 16'd1234, 48'h5a_11_22_33_44_55,
                                    32'hc0a8_020a, 16'd40000, 16, 0);
            endcase
            send_frame(16'h0800, 8'd17, LOCAL_IP, 16'd1234, 48'h3c_00_00_00_00_07,
                       32'h0a00_0001, 16'(5000 + k), 16, 0);
        end
        finish_test("test 2 filtering");

        send_frame(16'h0800, 8'd17, LOCAL_IP, 16'd1234, 48'h5a_11_22_33_44_55,
                   32'hc0a8_020a, 16'd40001, 4, 10);
        finish_test("test 3 padding");

        send_frame(16'h0800, 8'd17, LOCAL_IP, 16'd1234, 48'h5a_11_22_33_44_55,
                   32'hc0a8_020a, 16'd40002, 0, 0);
        finish_test("test 4 empty payload");

        random_ready = 1'b1;
        for (int k = 0; k < 10; k++) begin
            send_frame(16'h0800, 8'd17, LOCAL_IP, 16'd1234, 48'h3c_00_00_00_00_07,
                       32'h0a00_0002, 16'(rand_bits(16)), rand_len[k], 0);
        end
        finish_test("test 5 random back-to-back");
        random_ready = 1'b0;

        $display("5 tests, %0d failed, %0d byte checks, %0d errors", tests_failed, checks, errors);
        if (errors == 0 && tests_failed == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire
